// File: include/blit_defs.svh
// fixed 16-bit words and addresses; WORDS and LINES registers hold the count minus one
`ifndef BLIT_DEFS_SVH
`define BLIT_DEFS_SVH

`define BLIT_WORD_W         16      // VRAM data word
`define BLIT_ADDR_W         16      // VRAM word address
`define BLIT_REG_NUM_W      4       // local register number
`define BLIT_NIB_W          4       // nibbles per word, one mask bit each
`define BLIT_SHIFT_W        2       // nibble shift 0-3
`define BLIT_TVAL_W         8       // two transparent nibbles

// register numbers
`define BLIT_REG_CTRL       4'd0
`define BLIT_REG_VAL_C      4'd1
`define BLIT_REG_MOD_S      4'd2
`define BLIT_REG_SRC_S      4'd3    // source address, or the constant S
`define BLIT_REG_MOD_D      4'd4
`define BLIT_REG_DST_D      4'd5
`define BLIT_REG_SHIFT      4'd6
`define BLIT_REG_LINES      4'd7
`define BLIT_REG_WORDS      4'd8    // write queues the blit

// CTRL bit positions
`define BLIT_CTRL_S_CONST   0
`define BLIT_CTRL_C_AND     1
`define BLIT_CTRL_TRANSP    4
`define BLIT_CTRL_T_LSB     8       // high nibble for nibbles 3/1, low for 2/0

// SHIFT field positions
`define BLIT_SHIFT_F_LSB    12
`define BLIT_SHIFT_L_LSB    8
`define BLIT_SHIFT_A_LSB    0

`endif

// File: hdl/blit_pkg.sv
// vector types and sequencer encoding; every width here follows the defs header
`include "blit_defs.svh"

package blit_pkg;

    typedef logic [`BLIT_WORD_W-1:0]  word_t;
    typedef logic [`BLIT_ADDR_W-1:0]  addr_t;

    // bit 3 masks the high nibble
    typedef logic [`BLIT_NIB_W-1:0]   nib_mask_t;

    typedef logic [`BLIT_SHIFT_W-1:0] shift_t;

    typedef enum logic [2:0] {
        IDLE,       // wait for a queued blit
        SETUP,      // copy queued bank to working bank
        LINE_BEG,   // load counters, start first access of the line
        RD_S,       // source read
        WR_D,       // destination write
        LINE_END    // add modulo values, next line or finish
    } blit_state_t;

endpackage

// File: hdl/blit_regs.sv
// no back-pressure on writes; a write while full_o is high overwrites the queued blit
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_regs (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        reg_wr_i,
    input  logic [`BLIT_REG_NUM_W-1:0]  reg_num_i,
    input  blit_pkg::word_t             reg_data_i,
    input  logic                        setup_i,
    output logic                        full_o,
    output logic                        s_const_o,
    output logic                        c_and_o,
    output logic                        transp_o,
    output logic [`BLIT_TVAL_W-1:0]     transp_val_o,
    output blit_pkg::shift_t            shift_o,
    output blit_pkg::nib_mask_t         f_mask_o,
    output blit_pkg::nib_mask_t         l_mask_o,
    output blit_pkg::word_t             val_c_o,
    output blit_pkg::word_t             mod_s_o,
    output blit_pkg::word_t             src_s_o,
    output blit_pkg::word_t             mod_d_o,
    output blit_pkg::word_t             dst_d_o,
    output blit_pkg::word_t             lines_o,
    output blit_pkg::word_t             words_o
);
    import blit_pkg::*;

    logic                       q_s_const;
    logic                       q_c_and;
    logic                       q_transp;
    logic [`BLIT_TVAL_W-1:0]    q_transp_val;
    shift_t                     q_shift;
    nib_mask_t                  q_f_mask;
    nib_mask_t                  q_l_mask;
    word_t                      q_val_c;
    word_t                      q_mod_s;
    word_t                      q_src_s;
    word_t                      q_mod_d;
    word_t                      q_dst_d;
    word_t                      q_lines;
    word_t                      q_words;

    // queue flag and control fields of the queued bank
    always_ff @(posedge clk) begin
        if (reset_i) begin
            full_o       <= 1'b0;
            q_s_const    <= 1'b0;
            q_c_and      <= 1'b0;
            q_transp     <= 1'b0;
            q_transp_val <= '0;
            q_shift      <= '0;
            q_f_mask     <= '0;
            q_l_mask     <= '0;
        end else begin
            if (setup_i) begin
                full_o <= 1'b0;
            end
            if (reg_wr_i && reg_num_i == `BLIT_REG_WORDS) begin
                full_o <= 1'b1;                             // wins over setup, re-queues
            end
            if (reg_wr_i && reg_num_i == `BLIT_REG_CTRL) begin
                q_s_const    <= reg_data_i[`BLIT_CTRL_S_CONST];
                q_c_and      <= reg_data_i[`BLIT_CTRL_C_AND];
                q_transp     <= reg_data_i[`BLIT_CTRL_TRANSP];
                q_transp_val <= reg_data_i[`BLIT_CTRL_T_LSB +: `BLIT_TVAL_W];
            end
            if (reg_wr_i && reg_num_i == `BLIT_REG_SHIFT) begin
                q_f_mask <= reg_data_i[`BLIT_SHIFT_F_LSB +: `BLIT_NIB_W];
                q_l_mask <= reg_data_i[`BLIT_SHIFT_L_LSB +: `BLIT_NIB_W];
                q_shift  <= reg_data_i[`BLIT_SHIFT_A_LSB +: `BLIT_SHIFT_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr_i) begin
            case (reg_num_i)
                `BLIT_REG_VAL_C: q_val_c <= reg_data_i;
                `BLIT_REG_MOD_S: q_mod_s <= reg_data_i;
                `BLIT_REG_SRC_S: q_src_s <= reg_data_i;
                `BLIT_REG_MOD_D: q_mod_d <= reg_data_i;
                `BLIT_REG_DST_D: q_dst_d <= reg_data_i;
                `BLIT_REG_LINES: q_lines <= reg_data_i;
                `BLIT_REG_WORDS: q_words <= reg_data_i;
                default: ;
            endcase
        end
    end

    // working bank, valid from the cycle after setup
    always_ff @(posedge clk) begin
        if (reset_i) begin
            s_const_o    <= 1'b0;
            c_and_o      <= 1'b0;
            transp_o     <= 1'b0;
            transp_val_o <= '0;
            shift_o      <= '0;
            f_mask_o     <= '0;
            l_mask_o     <= '0;
        end else if (setup_i) begin
            s_const_o    <= q_s_const;
            c_and_o      <= q_c_and;
            transp_o     <= q_transp;
            transp_val_o <= q_transp_val;
            shift_o      <= q_shift;
            f_mask_o     <= q_f_mask;
            l_mask_o     <= q_l_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (setup_i) begin
            val_c_o <= q_val_c;
            mod_s_o <= q_mod_s;
            src_s_o <= q_src_s;
            mod_d_o <= q_mod_d;
            dst_d_o <= q_dst_d;
            lines_o <= q_lines;
            words_o <= q_words;
        end
    end

endmodule

// File: hdl/blit_seq.sv
// WORDS and LINES hold count minus one (1-65536 words, 1-32768 lines); VRAM outputs held until ack
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_seq (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                full_i,
    input  logic                s_const_i,
    input  blit_pkg::addr_t     src_s_i,
    input  blit_pkg::addr_t     dst_d_i,
    input  blit_pkg::addr_t     mod_s_i,
    input  blit_pkg::addr_t     mod_d_i,
    input  blit_pkg::word_t     lines_i,
    input  blit_pkg::word_t     words_i,
    input  logic                vram_ack_i,
    output logic                setup_o,
    output logic                line_beg_o,
    output logic                rd_acc_o,
    output logic                wr_acc_o,
    output logic                last_word_o,
    output logic                busy_o,
    output logic                done_o,
    output logic                vram_sel_o,
    output logic                vram_wr_o,
    output blit_pkg::addr_t     vram_addr_o
);
    import blit_pkg::*;

    blit_state_t            state_q;
    blit_state_t            state_n;
    logic                   sel_n;
    logic                   wr_n;
    addr_t                  addr_n;
    addr_t                  src_q;
    addr_t                  src_n;
    addr_t                  dst_q;
    addr_t                  dst_n;
    word_t                  lines_q;        // bit 15 set on the last line
    word_t                  lines_n;
    logic [`BLIT_WORD_W:0]  count_q;        // bit 16 set on the last word
    logic [`BLIT_WORD_W:0]  count_n;
    logic                   first_q;        // first LINE_BEG of a blit
    logic                   advance;
    addr_t                  src_cur;
    addr_t                  dst_cur;
    word_t                  lines_cur;

    assign advance     = !vram_sel_o || vram_ack_i;     // stall while an access waits

    // the working bank only becomes valid in the first LINE_BEG
    assign src_cur     = first_q ? src_s_i : src_q;
    assign dst_cur     = first_q ? dst_d_i : dst_q;
    assign lines_cur   = first_q ? lines_i : lines_q;

    assign busy_o      = (state_q != IDLE);
    assign done_o      = (state_q == LINE_END) && lines_q[`BLIT_WORD_W-1];
    assign setup_o     = (state_q == SETUP);
    assign line_beg_o  = (state_q == LINE_BEG);     // LINE_BEG never stalls
    assign rd_acc_o    = (state_q == RD_S) && vram_ack_i;
    assign wr_acc_o    = (state_q == WR_D) && vram_ack_i;
    assign last_word_o = count_q[`BLIT_WORD_W];

    always_comb begin
        state_n = state_q;
        sel_n   = 1'b0;
        wr_n    = 1'b0;
        addr_n  = vram_addr_o;
        src_n   = src_q;
        dst_n   = dst_q;
        lines_n = lines_q;
        count_n = count_q;
        case (state_q)
            IDLE: begin
                if (full_i) begin
                    state_n = SETUP;
                end
            end
            SETUP: begin
                state_n = LINE_BEG;
            end
            LINE_BEG: begin
                src_n   = src_cur;
                dst_n   = dst_cur;
                lines_n = lines_cur - 1'b1;                 // pre-decrement, underflow = last
                count_n = {1'b0, words_i} - 1'b1;
                sel_n   = 1'b1;
                if (s_const_i) begin
                    wr_n    = 1'b1;
                    addr_n  = dst_cur;
                    state_n = WR_D;
                end else begin
                    addr_n  = src_cur;
                    state_n = RD_S;
                end
            end
            RD_S: begin
                src_n   = vram_addr_o + 1'b1;
                sel_n   = 1'b1;
                wr_n    = 1'b1;
                addr_n  = dst_q;
                state_n = WR_D;
            end
            WR_D: begin
                dst_n   = vram_addr_o + 1'b1;
                count_n = count_q - 1'b1;
                if (last_word_o) begin
                    state_n = LINE_END;
                end else if (s_const_i) begin
                    sel_n   = 1'b1;                         // back-to-back writes
                    wr_n    = 1'b1;
                    addr_n  = vram_addr_o + 1'b1;
                end else begin
                    sel_n   = 1'b1;
                    addr_n  = src_q;
                    state_n = RD_S;
                end
            end
            LINE_END: begin
                src_n = src_q + mod_s_i;
                dst_n = dst_q + mod_d_i;
                if (!lines_q[`BLIT_WORD_W-1]) begin
                    state_n = LINE_BEG;
                end else if (full_i) begin
                    state_n = SETUP;                        // next blit already queued
                end else begin
                    state_n = IDLE;
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= IDLE;
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
            first_q    <= 1'b0;
            lines_q    <= '0;
            count_q    <= '0;
        end else begin
            first_q <= (state_q == SETUP);
            if (advance) begin
                state_q    <= state_n;
                vram_sel_o <= sel_n;
                vram_wr_o  <= wr_n;
                lines_q    <= lines_n;
                count_q    <= count_n;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            vram_addr_o <= addr_n;
            src_q       <= src_n;
            dst_q       <= dst_n;
        end
    end

endmodule

// File: hdl/blit_datapath.sv
// constant S is taken the cycle after setup; the stored source bits are cleared only by reset
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_datapath (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        setup_i,
    input  logic                        line_beg_i,
    input  logic                        rd_acc_i,
    input  logic                        wr_acc_i,
    input  logic                        last_word_i,
    input  blit_pkg::word_t             src_s_i,
    input  blit_pkg::word_t             val_c_i,
    input  logic                        c_and_i,
    input  logic                        transp_i,
    input  logic [`BLIT_TVAL_W-1:0]     transp_val_i,
    input  blit_pkg::shift_t            shift_i,
    input  blit_pkg::nib_mask_t         f_mask_i,
    input  blit_pkg::nib_mask_t         l_mask_i,
    input  blit_pkg::word_t             vram_data_i,
    output blit_pkg::word_t             vram_data_o,
    output blit_pkg::nib_mask_t         vram_wr_mask_o
);
    import blit_pkg::*;

    word_t          s_q;            // current S word
    logic [11:0]    prev_q;         // low three nibbles of the last read
    nib_mask_t      f_mask_q;
    nib_mask_t      t_mask;
    logic           setup_q;

    // right shift by nibbles, freed nibbles come from the previous word
    function automatic word_t shifter(input shift_t amt, input word_t data, input logic [11:0] prev);
        case (amt)
            2'd0:    return data;
            2'd1:    return {prev[3:0], data[15:4]};
            2'd2:    return {prev[7:0], data[15:8]};
            default: return {prev, data[15:12]};
        endcase
    endfunction

    // nibbles 3 and 1 compare with the high value, 2 and 0 with the low
    assign t_mask = transp_i ? {s_q[15:12] != transp_val_i[7:4],
                                s_q[11:8]  != transp_val_i[3:0],
                                s_q[7:4]   != transp_val_i[7:4],
                                s_q[3:0]   != transp_val_i[3:0]} : 4'hF;

    assign vram_data_o    = c_and_i ? (s_q & val_c_i) : (s_q ^ val_c_i);
    assign vram_wr_mask_o = f_mask_q & (last_word_i ? l_mask_i : 4'hF) & t_mask;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            setup_q  <= 1'b0;
            prev_q   <= '0;
            f_mask_q <= '0;
        end else begin
            setup_q <= setup_i;
            if (rd_acc_i) begin
                prev_q <= vram_data_i[11:0];
            end
            if (line_beg_i) begin
                f_mask_q <= f_mask_i;
            end else if (wr_acc_i) begin
                f_mask_q <= '1;                             // first word done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (setup_q) begin
            s_q <= src_s_i;                                 // constant S
        end else if (rd_acc_i) begin
            s_q <= shifter(shift_i, vram_data_i, prev_q);
        end
    end

endmodule

// File: hdl/blitter.sv
// sole master on its VRAM port; the host should wait for full_o low before queueing again
`timescale 1ns/1ps
`include "blit_defs.svh"

module blitter (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        reg_wr_i,
    input  logic [`BLIT_REG_NUM_W-1:0]  reg_num_i,
    input  blit_pkg::word_t             reg_data_i,
    output logic                        busy_o,
    output logic                        full_o,
    output logic                        done_o,
    output logic                        vram_sel_o,
    output logic                        vram_wr_o,
    output blit_pkg::nib_mask_t         vram_wr_mask_o,
    output blit_pkg::addr_t             vram_addr_o,
    output blit_pkg::word_t             vram_data_o,
    input  logic                        vram_ack_i,
    input  blit_pkg::word_t             vram_data_i
);
    import blit_pkg::*;

    logic                       setup;
    logic                       line_beg;
    logic                       rd_acc;
    logic                       wr_acc;
    logic                       last_word;
    logic                       s_const;
    logic                       c_and;
    logic                       transp;
    logic [`BLIT_TVAL_W-1:0]    transp_val;
    shift_t                     shift;
    nib_mask_t                  f_mask;
    nib_mask_t                  l_mask;
    word_t                      val_c;
    word_t                      mod_s;
    word_t                      src_s;
    word_t                      mod_d;
    word_t                      dst_d;
    word_t                      lines;
    word_t                      words;

    blit_regs u_regs (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
        .setup_i(setup), .full_o(full_o),
        .s_const_o(s_const), .c_and_o(c_and), .transp_o(transp), .transp_val_o(transp_val),
        .shift_o(shift), .f_mask_o(f_mask), .l_mask_o(l_mask),
        .val_c_o(val_c), .mod_s_o(mod_s), .src_s_o(src_s), .mod_d_o(mod_d),
        .dst_d_o(dst_d), .lines_o(lines), .words_o(words)
    );

    blit_seq u_seq (
        .clk(clk), .reset_i(reset_i), .full_i(full_o), .s_const_i(s_const),
        .src_s_i(src_s), .dst_d_i(dst_d), .mod_s_i(mod_s), .mod_d_i(mod_d),
        .lines_i(lines), .words_i(words), .vram_ack_i(vram_ack_i),
        .setup_o(setup), .line_beg_o(line_beg), .rd_acc_o(rd_acc), .wr_acc_o(wr_acc),
        .last_word_o(last_word), .busy_o(busy_o), .done_o(done_o),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o), .vram_addr_o(vram_addr_o)
    );

    blit_datapath u_datapath (
        .clk(clk), .reset_i(reset_i), .setup_i(setup), .line_beg_i(line_beg),
        .rd_acc_i(rd_acc), .wr_acc_i(wr_acc), .last_word_i(last_word),
        .src_s_i(src_s), .val_c_i(val_c), .c_and_i(c_and),
        .transp_i(transp), .transp_val_i(transp_val), .shift_i(shift),
        .f_mask_i(f_mask), .l_mask_i(l_mask), .vram_data_i(vram_data_i),
        .vram_data_o(vram_data_o), .vram_wr_mask_o(vram_wr_mask_o)
    );

endmodule

// File: tb/blit_chk.sv
// VRAM handshake and status properties; only meaningful with a single master on the VRAM port
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_chk (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                busy_o,
    input  logic                done_o,
    input  logic                vram_sel_o,
    input  logic                vram_wr_o,
    input  logic                vram_ack_i,
    input  blit_pkg::addr_t     vram_addr_o,
    input  blit_pkg::word_t     vram_data_o
);
    // a waiting request keeps all its outputs
    a_req_hold: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o && !vram_ack_i |=> vram_sel_o && $stable(vram_addr_o)
            && $stable(vram_wr_o) && $stable(vram_data_o))
        else $error("VRAM request changed before ack");

    a_done_pulse: assert property (@(posedge clk) disable iff (reset_i)
        done_o |=> !done_o)
        else $error("done_o longer than one cycle");

    a_sel_busy: assert property (@(posedge clk) disable iff (reset_i)
        !busy_o |-> !vram_sel_o)
        else $error("VRAM select while idle");

endmodule

bind blitter blit_chk u_chk (
    .clk(clk), .reset_i(reset_i), .busy_o(busy_o), .done_o(done_o),
    .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o), .vram_ack_i(vram_ack_i),
    .vram_addr_o(vram_addr_o), .vram_data_o(vram_data_o)
);

// File: tb/blitter_tb.sv
// self-checking run with a 64K-word VRAM model; blits are kept small (8 words x 4 lines at most)
`timescale 1ns/1ps
`include "blit_defs.svh"

module blitter_tb;
    import blit_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_BLITS   = 56;
    localparam int MAX_WORDS   = 8;
    localparam int MAX_LINES   = 4;
    localparam int BLIT_BUDGET = MAX_WORDS * MAX_LINES * 2 * 5 + 100;    // cycles per blit

    typedef struct packed {
        logic        s_const;
        logic        c_and;
        logic        transp;
        logic [7:0]  tval;
        logic [1:0]  shift;
        logic [3:0]  fmask;
        logic [3:0]  lmask;
        logic [15:0] val_c;
        logic [15:0] mod_s;
        logic [15:0] src_s;
        logic [15:0] mod_d;
        logic [15:0] dst_d;
        logic [15:0] lines;
        logic [15:0] words;
    } cfg_t;

    logic        clk;
    logic        reset_i;
    logic        reg_wr_i;
    logic [3:0]  reg_num_i;
    word_t       reg_data_i;
    logic        busy_o;
    logic        full_o;
    logic        done_o;
    logic        vram_sel_o;
    logic        vram_wr_o;
    nib_mask_t   vram_wr_mask_o;
    addr_t       vram_addr_o;
    word_t       vram_data_o;
    logic        vram_ack_i;
    word_t       vram_data_i;

    word_t       mem [0:65535];
    word_t       shadow [0:65535];
    logic [11:0] model_prev;            // stored source bits, cleared only at reset
    addr_t       touched [$];
    cfg_t        pending [$];
    integer      seed;
    integer      ack_seed;
    int          wait_cnt;
    int          rd_count;
    int          wr_count;
    int          done_count;
    int          errors;
    int          proto_errors;
    string       cur_test;

    blitter UUT (
        .clk(clk), .reset_i(reset_i), .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .busy_o(busy_o), .full_o(full_o), .done_o(done_o),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o), .vram_wr_mask_o(vram_wr_mask_o),
        .vram_addr_o(vram_addr_o), .vram_data_o(vram_data_o),
        .vram_ack_i(vram_ack_i), .vram_data_i(vram_data_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // VRAM with 0-3 cycles of extra ack delay
    always @(posedge clk) begin
        if (reset_i) begin
            vram_ack_i <= 1'b0;
            wait_cnt   <= 0;
        end else if (vram_ack_i) begin
            vram_ack_i <= 1'b0;
        end else if (vram_sel_o) begin
            if (wait_cnt == 0) begin
                vram_ack_i <= 1'b1;
                if (vram_wr_o) begin
                    for (int n = 0; n < 4; n++) begin
                        if (vram_wr_mask_o[n]) begin
                            mem[vram_addr_o][4*n +: 4] <= vram_data_o[4*n +: 4];
                        end
                    end
                    wr_count++;
                end else begin
                    vram_data_i <= mem[vram_addr_o];
                    rd_count++;
                end
                wait_cnt <= $random(ack_seed) & 3;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // reference model of one blit, applied to the shadow memory in access order
    task automatic model_blit(input cfg_t c);
        logic [15:0] src;
        logic [15:0] dst;
        logic [15:0] s;
        logic [15:0] d;
        logic [15:0] data;
        logic [27:0] cat;
        logic [3:0]  m;
        logic [3:0]  tn;
        touched.delete();
        src = c.src_s;
        dst = c.dst_d;
        for (int ln = 0; ln <= int'(c.lines); ln++) begin
            for (int wd = 0; wd <= int'(c.words); wd++) begin
                if (c.s_const) begin
                    s = c.src_s;
                end else begin
                    data = shadow[src];
                    cat = {model_prev, data} >> (4 * c.shift);
                    s = cat[15:0];
                    model_prev = data[11:0];
                    src = src + 16'd1;
                end
                d = c.c_and ? (s & c.val_c) : (s ^ c.val_c);
                m = 4'hF;
                if (wd == 0) m = m & c.fmask;
                if (wd == int'(c.words)) m = m & c.lmask;
                for (int n = 0; n < 4; n++) begin
                    tn = (n % 2) ? c.tval[7:4] : c.tval[3:0];
                    if (c.transp && s[4*n +: 4] == tn) m[n] = 1'b0;
                    if (m[n]) shadow[dst][4*n +: 4] = d[4*n +: 4];
                end
                touched.push_back(dst);
                dst = dst + 16'd1;
            end
            src = src + c.mod_s;
            dst = dst + c.mod_d;
        end
    endtask

    task automatic check_done();
        cfg_t c;
        if (pending.size() == 0) begin
            proto_errors++;
            $display("%s: done pulse without a queued blit", cur_test);
        end else begin
            c = pending.pop_front();
            model_blit(c);
            foreach (touched[i]) begin
                if (mem[touched[i]] !== shadow[touched[i]]) begin
                    errors++;
                    $display("Error %s addr %h expected %h actual %h", cur_test, touched[i],
                             shadow[touched[i]], mem[touched[i]]);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset_i && done_o) begin
            check_done();
            done_count <= done_count + 1;
        end
    end

    task automatic write_reg(input logic [3:0] num, input logic [15:0] data);
        @(posedge clk);
        reg_wr_i   <= 1'b1;
        reg_num_i  <= num;
        reg_data_i <= data;
        @(posedge clk);
        reg_wr_i   <= 1'b0;
    endtask

    task automatic program_blit(input cfg_t c);
        logic [15:0] ctrl;
        logic [15:0] shf;
        ctrl = 16'h0;
        ctrl[`BLIT_CTRL_S_CONST] = c.s_const;
        ctrl[`BLIT_CTRL_C_AND]   = c.c_and;
        ctrl[`BLIT_CTRL_TRANSP]  = c.transp;
        ctrl[`BLIT_CTRL_T_LSB +: 8] = c.tval;
        shf = 16'h0;
        shf[`BLIT_SHIFT_F_LSB +: 4] = c.fmask;
        shf[`BLIT_SHIFT_L_LSB +: 4] = c.lmask;
        shf[`BLIT_SHIFT_A_LSB +: 2] = c.shift;
        write_reg(`BLIT_REG_CTRL, ctrl);
        write_reg(`BLIT_REG_VAL_C, c.val_c);
        write_reg(`BLIT_REG_MOD_S, c.mod_s);
        write_reg(`BLIT_REG_SRC_S, c.src_s);
        write_reg(`BLIT_REG_MOD_D, c.mod_d);
        write_reg(`BLIT_REG_DST_D, c.dst_d);
        write_reg(`BLIT_REG_SHIFT, shf);
        write_reg(`BLIT_REG_LINES, c.lines);
        pending.push_back(c);
        write_reg(`BLIT_REG_WORDS, c.words);
    endtask

    task automatic random_cfg(output cfg_t c, input logic s_const);
        c.s_const = s_const;
        c.c_and   = $random(seed);
        c.transp  = $random(seed);
        c.tval    = $random(seed);
        c.shift   = $random(seed);
        c.fmask   = $random(seed);
        c.lmask   = $random(seed);
        c.val_c   = $random(seed);
        c.mod_s   = $random(seed) & 15;
        c.src_s   = $random(seed);
        c.mod_d   = $random(seed) & 15;
        c.dst_d   = $random(seed);
        c.lines   = $random(seed) & (MAX_LINES - 1);
        c.words   = $random(seed) & (MAX_WORDS - 1);
    endtask

    task automatic wait_done(input int target);
        int cyc;
        cyc = 0;
        while (done_count < target && cyc < 2 * BLIT_BUDGET) begin
            @(posedge clk);
            cyc++;
        end
        if (done_count < target) begin
            proto_errors++;
            $display("%s: timed out waiting for done_o", cur_test);
        end
    endtask

    task automatic run_blit(input cfg_t c);
        int base;
        while (busy_o || full_o) @(posedge clk);
        base = done_count;
        program_blit(c);
        wait_done(base + 1);
    endtask

    initial begin
        #(NUM_BLITS * BLIT_BUDGET * CLK_PERIOD);
        $display("watchdog expired, simulation stopped");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        cfg_t  c;
        cfg_t  b;
        word_t old;
        int    reads;
        int    writes;
        int    base;
        int    cyc;
        seed = 8;
        ack_seed = 8;
        clk = 1'b0;
        reset_i = 1'b1;
        reg_wr_i = 1'b0;
        reg_num_i = '0;
        reg_data_i = '0;
        vram_ack_i = 1'b0;
        vram_data_i = '0;
        model_prev = '0;
        rd_count = 0;
        wr_count = 0;
        done_count = 0;
        errors = 0;
        proto_errors = 0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = a[15:0] ^ {a[7:0], a[15:8]} ^ 16'hA5C3;   // depends on every address bit
            shadow[a] = mem[a];
        end
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        cur_test = "reset";
        repeat (8) begin
            @(posedge clk);
            if (busy_o || full_o || done_o || vram_sel_o) begin
                proto_errors++;
                $display("reset: status or VRAM select not low after reset");
            end
        end
        if (rd_count + wr_count != 0) begin
            proto_errors++;
            $display("reset: VRAM accessed without a blit");
        end

        cur_test = "copy_line";
        random_cfg(c, 1'b0);
        c.lines = 0;
        c.c_and = 1'b0;
        c.transp = 1'b0;
        run_blit(c);

        cur_test = "fill_and";
        random_cfg(c, 1'b1);
        c.c_and = 1'b1;
        c.transp = 1'b0;
        c.lines = 3;
        c.mod_d = 16'd5;
        reads = rd_count;
        writes = wr_count;
        run_blit(c);
        if (rd_count != reads) begin
            proto_errors++;
            $display("fill_and: VRAM read during a constant fill");
        end
        if (wr_count - writes != (int'(c.words) + 1) * (int'(c.lines) + 1)) begin
            errors++;
            $display("Error %s write count expected %0d actual %0d", cur_test,
                     (int'(c.words) + 1) * (int'(c.lines) + 1), wr_count - writes);
        end

        cur_test = "transparency";
        random_cfg(c, 1'b1);
        c.transp = 1'b1;
        c.tval = 8'h5A;
        c.src_s = 16'h5A3A;                                 // only nibble 1 is opaque
        c.c_and = 1'b0;
        c.val_c = 16'h0;
        c.fmask = 4'hF;
        c.lmask = 4'hF;
        c.words = 0;
        c.lines = 0;
        old = mem[c.dst_d];
        run_blit(c);
        if (mem[c.dst_d] !== {old[15:8], 4'h3, old[3:0]}) begin
            errors++;
            $display("Error %s expected %h actual %h", cur_test,
                     {old[15:8], 4'h3, old[3:0]}, mem[c.dst_d]);
        end
        random_cfg(c, 1'b0);
        c.transp = 1'b1;
        run_blit(c);

        cur_test = "queued";
        random_cfg(c, 1'b0);
        c.words = MAX_WORDS - 1;
        c.lines = MAX_LINES - 1;
        random_cfg(b, 1'b0);
        while (busy_o || full_o) @(posedge clk);
        base = done_count;
        program_blit(c);
        cyc = 0;
        while ((full_o || !busy_o) && cyc < BLIT_BUDGET) begin    // first blit under way
            @(posedge clk);
            cyc++;
        end
        program_blit(b);
        @(posedge clk);
        if (!full_o || !busy_o) begin
            proto_errors++;
            $display("queued: second blit not held in the queue");
        end
        while (done_count < base + 1 && cyc < 2 * BLIT_BUDGET) begin
            if (!full_o) begin
                proto_errors++;
                $display("queued: full_o dropped before the second blit started");
            end
            @(posedge clk);
            cyc++;
        end
        wait_done(base + 2);

        cur_test = "random";
        for (int i = 0; i < 50; i++) begin
            random_cfg(c, $random(seed));
            run_blit(c);
        end

        repeat (4) @(posedge clk);
        $display("value errors %0d, other errors %0d", errors, proto_errors);
        if (errors == 0 && proto_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
hdl/blit_pkg.sv
hdl/blit_regs.sv
hdl/blit_seq.sv
hdl/blit_datapath.sv
hdl/blitter.sv
tb/blit_chk.sv
tb/blitter_tb.sv
